//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_blitter
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- blit_engine.sv
`timescale 1ns/1ps

module blit_engine import blit_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        a_const_i,
    input  logic        b_const_i,
    input  logic        b_not_i,
    input  logic        c_use_b_i,
    input  logic        t8_i,
    input  logic [7:0]  transp_i,
    input  shift_t      shift_i,
    input  nib_mask_t   f_mask_i,
    input  nib_mask_t   l_mask_i,
    input  word_t       mod_a_i,
    input  word_t       mod_b_i,
    input  word_t       mod_d_i,
    input  word_t       src_a_i,
    input  word_t       src_b_i,
    input  word_t       val_c_i,
    input  word_t       dst_d_i,
    input  word_t       lines_i,
    input  word_t       words_i,
    input  logic        queued_i,
    output logic        setup_o,        // copy strobe back to the register file
    output logic        busy_o,
    output logic        done_o,
    output logic        vram_sel_o,
    output logic        vram_wr_o,
    output addr_t       vram_addr_o,
    output word_t       vram_data_o,
    output nib_mask_t   vram_wr_mask_o,
    input  logic        vram_ack_i,
    input  word_t       vram_data_i
);

    typedef enum logic [2:0] {
        IDLE, SETUP, LINE_BEG, RD_A, RD_B, WR_D, LINE_END
    } state_t;

    state_t     state, state_next;

    // working copy of the blit
    logic       a_const, b_const, b_not, c_use_b, t8;
    logic [7:0] transp;
    shift_t     shift;
    nib_mask_t  f_mask, l_mask;
    word_t      mod_a, mod_b, mod_d;
    word_t      src_a, src_b, dst_d, val_c;
    word_t      lines, words;
    logic [16:0] count;                 // bit 16 flags the last word of a line

    word_t      val_a, val_b, val_b_prime;
    nib_mask_t  first_mask;

    word_t      src_a_next, src_b_next, dst_d_next;
    word_t      val_a_next, val_b_next;
    word_t      lines_next;
    logic [16:0] count_next;
    nib_mask_t  first_mask_next;
    logic       sel_next;
    addr_t      addr_next;

    word_t      shifted_a, shifted_b;
    logic       advance;

    assign advance     = !vram_sel_o || vram_ack_i;     // stall while an access is pending
    assign busy_o      = (state != IDLE);
    assign done_o      = (state == LINE_END) && lines[15];
    assign vram_data_o = val_a & val_b_prime ^ val_c;

    blit_shifter shift_a (
        .clk       (clk),
        .reset_i   (reset_i),
        .load_i    (state == RD_A && vram_ack_i),
        .amount_i  (shift),
        .data_i    (vram_data_i),
        .shifted_o (shifted_a)
    );

    blit_shifter shift_b (
        .clk       (clk),
        .reset_i   (reset_i),
        .load_i    (state == RD_B && vram_ack_i),
        .amount_i  (shift),
        .data_i    (vram_data_i),
        .shifted_o (shifted_b)
    );

    blit_write_mask write_mask (
        .first_mask_i (first_mask),
        .last_mask_i  (l_mask),
        .last_word_i  (count[16]),
        .t8_i         (t8),
        .transp_i     (transp),
        .b_i          (val_b),
        .mask_o       (vram_wr_mask_o)
    );

    // first access of a word, skipping constant sources
    function automatic state_t word_start(input logic a_c, input logic b_c);
        if (!a_c) begin
            return RD_A;
        end else if (!b_c) begin
            return RD_B;
        end
        return WR_D;
    endfunction

    always_comb begin
        state_next      = state;
        setup_o         = 1'b0;
        src_a_next      = src_a;
        src_b_next      = src_b;
        dst_d_next      = dst_d;
        val_a_next      = val_a;
        val_b_next      = val_b;
        lines_next      = lines;
        count_next      = count;
        first_mask_next = first_mask;

        case (state)
            IDLE: begin
                if (queued_i) begin
                    state_next = SETUP;
                end
            end
            SETUP: begin
                setup_o    = 1'b1;
                state_next = LINE_BEG;
            end
            LINE_BEG: begin
                first_mask_next = f_mask;
                lines_next      = lines - 1'b1;             // underflow into bit 15 marks last line
                count_next      = {1'b0, words} - 1'b1;
                state_next      = word_start(a_const, b_const);
            end
            RD_A: begin
                val_a_next = shifted_a;
                src_a_next = src_a + 1'b1;
                state_next = b_const ? WR_D : RD_B;
            end
            RD_B: begin
                val_b_next = shifted_b;
                src_b_next = src_b + 1'b1;
                state_next = WR_D;
            end
            WR_D: begin
                dst_d_next      = dst_d + 1'b1;
                count_next      = count - 1'b1;
                first_mask_next = '1;
                state_next      = count[16] ? LINE_END : word_start(a_const, b_const);
            end
            LINE_END: begin
                src_a_next = src_a + mod_a;                 // skip to the next line
                src_b_next = src_b + mod_b;
                dst_d_next = dst_d + mod_d;
                if (!lines[15]) begin
                    state_next = LINE_BEG;
                end else begin
                    state_next = queued_i ? SETUP : IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase

        sel_next = (state_next == RD_A) || (state_next == RD_B) || (state_next == WR_D);
        case (state_next)
            RD_A:    addr_next = src_a_next;
            RD_B:    addr_next = src_b_next;
            WR_D:    addr_next = dst_d_next;
            default: addr_next = vram_addr_o;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= IDLE;
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
        end else if (advance) begin
            state      <= state_next;
            vram_sel_o <= sel_next;
            vram_wr_o  <= (state_next == WR_D);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            vram_addr_o <= addr_next;
            src_a       <= src_a_next;
            src_b       <= src_b_next;
            dst_d       <= dst_d_next;
            val_a       <= val_a_next;
            val_b       <= val_b_next;
            val_b_prime <= b_not ? ~val_b_next : val_b_next;
            val_c       <= c_use_b ? val_b_next : val_c;
            lines       <= lines_next;
            count       <= count_next;
            first_mask  <= first_mask_next;
        end
        if (setup_o) begin
            a_const <= a_const_i;
            b_const <= b_const_i;
            b_not   <= b_not_i;
            c_use_b <= c_use_b_i;
            t8      <= t8_i;
            transp  <= transp_i;
            shift   <= shift_i;
            f_mask  <= f_mask_i;
            l_mask  <= l_mask_i;
            mod_a   <= mod_a_i;
            mod_b   <= mod_b_i;
            mod_d   <= mod_d_i;
            src_a   <= src_a_i;
            src_b   <= src_b_i;
            dst_d   <= dst_d_i;
            val_c   <= val_c_i;
            lines   <= lines_i;
            words   <= words_i;
            val_a   <= src_a_i;                             // sources double as constants
            val_b   <= src_b_i;
        end
    end

endmodule

//--- blit_pkg.sv
package blit_pkg;

    localparam int NIBBLES = 4;                     // 4-bit pixels per vram word

    typedef logic [15:0]        word_t;             // vram data word
    typedef logic [15:0]        addr_t;             // vram word address
    typedef logic [NIBBLES-1:0] nib_mask_t;         // one bit per nibble
    typedef logic [1:0]         shift_t;            // nibble shift amount
    typedef logic [3:0]         reg_num_t;          // blit register number

    // blit register map
    localparam reg_num_t REG_CTRL  = 4'd0;
    localparam reg_num_t REG_SHIFT = 4'd1;
    localparam reg_num_t REG_MOD_A = 4'd2;
    localparam reg_num_t REG_MOD_B = 4'd3;
    localparam reg_num_t REG_MOD_C = 4'd4;          // accepted, value ignored
    localparam reg_num_t REG_MOD_D = 4'd5;
    localparam reg_num_t REG_SRC_A = 4'd6;
    localparam reg_num_t REG_SRC_B = 4'd7;
    localparam reg_num_t REG_VAL_C = 4'd8;
    localparam reg_num_t REG_DST_D = 4'd9;
    localparam reg_num_t REG_LINES = 4'd10;         // line count minus one
    localparam reg_num_t REG_WORDS = 4'd11;         // word count minus one, queues the blit

    // CTRL register bits
    localparam int CTRL_A_CONST = 0;
    localparam int CTRL_B_CONST = 1;
    localparam int CTRL_B_NOT   = 2;
    localparam int CTRL_C_USE_B = 3;
    localparam int CTRL_T8      = 5;                // byte wide transparency test
    localparam int CTRL_T_LSB   = 8;                // transparency value in 15:8

    // SHIFT register fields, amount in 1:0
    localparam int SHIFT_F_LSB  = 12;               // first word mask
    localparam int SHIFT_L_LSB  = 8;                // last word mask

endpackage

//--- blit_regs.sv
`timescale 1ns/1ps

module blit_regs import blit_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        regs_wr_i,
    input  reg_num_t    reg_num_i,
    input  word_t       reg_data_i,
    input  logic        setup_i,        // engine copies the queued blit
    output logic        a_const_o,
    output logic        b_const_o,
    output logic        b_not_o,
    output logic        c_use_b_o,
    output logic        t8_o,
    output logic [7:0]  transp_o,
    output shift_t      shift_o,
    output nib_mask_t   f_mask_o,
    output nib_mask_t   l_mask_o,
    output word_t       mod_a_o,
    output word_t       mod_b_o,
    output word_t       mod_d_o,
    output word_t       src_a_o,
    output word_t       src_b_o,
    output word_t       val_c_o,
    output word_t       dst_d_o,
    output word_t       lines_o,
    output word_t       words_o,
    output logic        queued_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            a_const_o <= 1'b0;
            b_const_o <= 1'b0;
            b_not_o   <= 1'b0;
            c_use_b_o <= 1'b0;
            t8_o      <= 1'b0;
            transp_o  <= '0;
            shift_o   <= '0;
            f_mask_o  <= '0;
            l_mask_o  <= '0;
            queued_o  <= 1'b0;
        end else begin
            if (setup_i) begin
                queued_o <= 1'b0;
            end
            if (regs_wr_i) begin
                case (reg_num_i)
                    REG_CTRL: begin
                        a_const_o <= reg_data_i[CTRL_A_CONST];
                        b_const_o <= reg_data_i[CTRL_B_CONST];
                        b_not_o   <= reg_data_i[CTRL_B_NOT];
                        c_use_b_o <= reg_data_i[CTRL_C_USE_B];
                        t8_o      <= reg_data_i[CTRL_T8];
                        transp_o  <= reg_data_i[CTRL_T_LSB +: 8];
                    end
                    REG_SHIFT: begin
                        f_mask_o <= reg_data_i[SHIFT_F_LSB +: NIBBLES];
                        l_mask_o <= reg_data_i[SHIFT_L_LSB +: NIBBLES];
                        shift_o  <= reg_data_i[$bits(shift_t)-1:0];
                    end
                    REG_MOD_C: begin
                    end                                     // no C modulo in this engine
                    REG_WORDS: begin
                        queued_o <= 1'b1;                   // wins over a same cycle setup
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // address and count words, plain payload
    always_ff @(posedge clk) begin
        if (regs_wr_i) begin
            case (reg_num_i)
                REG_MOD_A: mod_a_o <= reg_data_i;
                REG_MOD_B: mod_b_o <= reg_data_i;
                REG_MOD_D: mod_d_o <= reg_data_i;
                REG_SRC_A: src_a_o <= reg_data_i;
                REG_SRC_B: src_b_o <= reg_data_i;
                REG_VAL_C: val_c_o <= reg_data_i;
                REG_DST_D: dst_d_o <= reg_data_i;
                REG_LINES: lines_o <= reg_data_i;
                REG_WORDS: words_o <= reg_data_i;
                default: begin
                end
            endcase
        end
    end

endmodule

//--- blit_shifter.sv
`timescale 1ns/1ps

module blit_shifter import blit_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    load_i,         // source word accepted this cycle
    input  shift_t  amount_i,       // nibbles to shift right
    input  word_t   data_i,
    output word_t   shifted_o
);

    word_t                          prev_word;      // last loaded source word
    logic [2*$bits(word_t)-1:0]     joined;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_word <= '0;
        end else if (load_i) begin
            prev_word <= data_i;
        end
    end

    // low nibbles of the previous word move in from the top
    assign joined    = {prev_word, data_i} >> {amount_i, 2'b00};
    assign shifted_o = joined[$bits(word_t)-1:0];

endmodule

//--- blit_write_mask.sv
`timescale 1ns/1ps

module blit_write_mask import blit_pkg::*; (
    input  nib_mask_t   first_mask_i,   // all ones after the first word of a line
    input  nib_mask_t   last_mask_i,
    input  logic        last_word_i,
    input  logic        t8_i,           // compare bytes instead of nibbles
    input  logic [7:0]  transp_i,
    input  word_t       b_i,
    output nib_mask_t   mask_o
);

    nib_mask_t  opaque4;
    nib_mask_t  opaque8;

    always_comb begin
        for (int n = 0; n < NIBBLES; n++) begin
            // odd nibbles against the high half, even against the low half
            opaque4[n] = b_i[4*n +: 4] != transp_i[4*(n%2) +: 4];
            opaque8[n] = b_i[8*(n/2) +: 8] != transp_i;        // both nibbles of a byte
        end
    end

    assign mask_o = first_mask_i &
                    (last_word_i ? last_mask_i : '1) &
                    (t8_i ? opaque8 : opaque4);

endmodule

//--- blitter.sv
`timescale 1ns/1ps

module blitter import blit_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        regs_wr_i,
    input  reg_num_t    reg_num_i,
    input  word_t       reg_data_i,
    input  logic        vram_ack_i,
    input  word_t       vram_data_i,
    output logic        busy_o,
    output logic        full_o,         // a blit is waiting in the registers
    output logic        done_o,
    output logic        vram_sel_o,
    output logic        vram_wr_o,
    output nib_mask_t   vram_wr_mask_o,
    output addr_t       vram_addr_o,
    output word_t       vram_data_o
);

    logic       a_const, b_const, b_not, c_use_b, t8;
    logic [7:0] transp;
    shift_t     shift;
    nib_mask_t  f_mask, l_mask;
    word_t      mod_a, mod_b, mod_d;
    word_t      src_a, src_b, val_c, dst_d;
    word_t      lines, words;
    logic       queued;
    logic       setup;

    assign full_o = queued;

    blit_regs regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .regs_wr_i  (regs_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .setup_i    (setup),
        .a_const_o  (a_const),
        .b_const_o  (b_const),
        .b_not_o    (b_not),
        .c_use_b_o  (c_use_b),
        .t8_o       (t8),
        .transp_o   (transp),
        .shift_o    (shift),
        .f_mask_o   (f_mask),
        .l_mask_o   (l_mask),
        .mod_a_o    (mod_a),
        .mod_b_o    (mod_b),
        .mod_d_o    (mod_d),
        .src_a_o    (src_a),
        .src_b_o    (src_b),
        .val_c_o    (val_c),
        .dst_d_o    (dst_d),
        .lines_o    (lines),
        .words_o    (words),
        .queued_o   (queued)
    );

    blit_engine engine (
        .clk            (clk),
        .reset_i        (reset_i),
        .a_const_i      (a_const),
        .b_const_i      (b_const),
        .b_not_i        (b_not),
        .c_use_b_i      (c_use_b),
        .t8_i           (t8),
        .transp_i       (transp),
        .shift_i        (shift),
        .f_mask_i       (f_mask),
        .l_mask_i       (l_mask),
        .mod_a_i        (mod_a),
        .mod_b_i        (mod_b),
        .mod_d_i        (mod_d),
        .src_a_i        (src_a),
        .src_b_i        (src_b),
        .val_c_i        (val_c),
        .dst_d_i        (dst_d),
        .lines_i        (lines),
        .words_i        (words),
        .queued_i       (queued),
        .setup_o        (setup),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .vram_sel_o     (vram_sel_o),
        .vram_wr_o      (vram_wr_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_o    (vram_data_o),
        .vram_wr_mask_o (vram_wr_mask_o),
        .vram_ack_i     (vram_ack_i),
        .vram_data_i    (vram_data_i)
    );

endmodule

//--- sources.f
blit_pkg.sv
blit_regs.sv
blit_shifter.sv
blit_write_mask.sv
blit_engine.sv
blitter.sv
tb_blitter.sv

//--- tb_blitter.sv
`timescale 1ns/1ps

module tb_blitter import blit_pkg::*; ();

    logic       clk = 1'b0;
    logic       reset_i;
    logic       regs_wr_i;
    reg_num_t   reg_num_i;
    word_t      reg_data_i;
    logic       vram_ack_i = 1'b0;
    word_t      vram_data_i = '0;
    logic       busy_o, full_o, done_o, vram_sel_o, vram_wr_o;
    nib_mask_t  vram_wr_mask_o;
    addr_t      vram_addr_o;
    word_t      vram_data_o;

    word_t      mem [0:65535];                  // vram model contents
    word_t      exp_mem [0:65535];              // expected image
    word_t      cfg [0:11];                     // register values of the next blit
    word_t      prev_a, prev_b;                 // shifter history of the expected image
    int         reads = 0;
    int         writes = 0;
    int         max_wr = -1;
    int         ack_wait = -1;
    int         exp_reads, exp_writes, exp_max_wr;

    always #4 clk = ~clk;

    blitter i_dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .regs_wr_i      (regs_wr_i),
        .reg_num_i      (reg_num_i),
        .reg_data_i     (reg_data_i),
        .vram_ack_i     (vram_ack_i),
        .vram_data_i    (vram_data_i),
        .busy_o         (busy_o),
        .full_o         (full_o),
        .done_o         (done_o),
        .vram_sel_o     (vram_sel_o),
        .vram_wr_o      (vram_wr_o),
        .vram_wr_mask_o (vram_wr_mask_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_o    (vram_data_o)
    );

    // vram with 0 to 3 idle cycles before each ack
    always @(posedge clk) begin
        #1;
        vram_ack_i = 1'b0;
        if (!reset_i && vram_sel_o) begin
            if (ack_wait < 0) begin
                ack_wait = int'($urandom_range(3, 0));
            end
            if (ack_wait == 0) begin
                if (vram_wr_o) begin
                    for (int n = 0; n < NIBBLES; n++) begin
                        if (vram_wr_mask_o[n]) begin
                            mem[vram_addr_o][4*n +: 4] = vram_data_o[4*n +: 4];
                        end
                    end
                    writes++;
                    if (int'(vram_addr_o) > max_wr) begin
                        max_wr = int'(vram_addr_o);
                    end
                end else begin
                    vram_data_i = mem[vram_addr_o];   // valid in the ack cycle
                    reads++;
                end
                vram_ack_i = 1'b1;
            end
            ack_wait--;
        end
    end

    // right shift by whole nibbles, the previous word fills from the top
    function automatic word_t shift_in(input word_t prev, input word_t cur, input int amount);
        logic [31:0] both;
        both = {prev, cur} >> (4 * amount);
        return both[15:0];
    endfunction

    function automatic nib_mask_t expected_mask(input int w, input word_t b);
        nib_mask_t  m;
        logic [3:0] key;
        word_t      ctrl;
        ctrl = cfg[REG_CTRL];
        for (int n = 0; n < NIBBLES; n++) begin
            if (ctrl[CTRL_T8]) begin
                m[n] = b[8*(n/2) +: 8] != ctrl[15:8];
            end else begin
                key  = (n % 2 == 1) ? ctrl[15:12] : ctrl[11:8];
                m[n] = b[4*n +: 4] != key;
            end
        end
        if (w == 0) begin
            m &= cfg[REG_SHIFT][15:12];
        end
        if (w == int'(cfg[REG_WORDS])) begin
            m &= cfg[REG_SHIFT][11:8];
        end
        return m;
    endfunction

    // applies the blit in cfg to the expected image
    function automatic void reference_blit();
        word_t      ctrl, sa, sb, sd, a, b, c, d;
        nib_mask_t  m;
        int         amount;
        ctrl   = cfg[REG_CTRL];
        amount = int'(cfg[REG_SHIFT][1:0]);
        sa     = cfg[REG_SRC_A];
        sb     = cfg[REG_SRC_B];
        sd     = cfg[REG_DST_D];
        a      = sa;                                // source values double as constants
        b      = sb;
        for (int l = 0; l <= int'(cfg[REG_LINES]); l++) begin
            for (int w = 0; w <= int'(cfg[REG_WORDS]); w++) begin
                if (!ctrl[CTRL_A_CONST]) begin
                    a      = shift_in(prev_a, exp_mem[sa], amount);
                    prev_a = exp_mem[sa];
                    sa++;
                    exp_reads++;
                end
                if (!ctrl[CTRL_B_CONST]) begin
                    b      = shift_in(prev_b, exp_mem[sb], amount);
                    prev_b = exp_mem[sb];
                    sb++;
                    exp_reads++;
                end
                c = ctrl[CTRL_C_USE_B] ? b : cfg[REG_VAL_C];
                d = (a & (ctrl[CTRL_B_NOT] ? ~b : b)) ^ c;
                m = expected_mask(w, b);
                for (int n = 0; n < NIBBLES; n++) begin
                    if (m[n]) begin
                        exp_mem[sd][4*n +: 4] = d[4*n +: 4];
                    end
                end
                exp_writes++;
                if (int'(sd) > exp_max_wr) begin
                    exp_max_wr = int'(sd);
                end
                sd++;
            end
            sa += cfg[REG_MOD_A];
            sb += cfg[REG_MOD_B];
            sd += cfg[REG_MOD_D];
        end
    endfunction

    task automatic abort_run(input string why);
        $display("FAIL: see errors above");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        assert (actual == expected) else begin
            $display("ERROR %s: %s expected %0h actual %0h", test, what, expected, actual);
            abort_run("a checked value is wrong");
        end
    endtask

    task automatic check_memory(input string test);
        for (int i = 0; i < 65536; i++) begin
            assert (mem[i] == exp_mem[i]) else begin
                $display("ERROR %s: word %h expected %h actual %h",
                         test, i[15:0], exp_mem[i], mem[i]);
                abort_run("vram contents differ from the expected image");
            end
        end
        check_value(test, "reads", exp_reads, reads);
        check_value(test, "writes", exp_writes, writes);
        check_value(test, "highest address written", exp_max_wr, max_wr);
    endtask

    task automatic wait_done(input string test);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 5000) begin
                $display("%s: the blit never signalled done", test);
                abort_run("timeout waiting for done");
            end
        end while (!done_o);
    endtask

    task automatic wait_not_full(input string test);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 5000) begin
                $display("%s: the queued blit was never taken", test);
                abort_run("timeout waiting for the queue to empty");
            end
        end while (full_o);
    endtask

    task automatic set_blit(input word_t ctrl, shift, src_a, src_b, val_c, dst_d,
                            mod_a, mod_b, mod_d, lines, words);
        cfg[REG_CTRL]  = ctrl;
        cfg[REG_SHIFT] = shift;
        cfg[REG_MOD_A] = mod_a;
        cfg[REG_MOD_B] = mod_b;
        cfg[REG_MOD_C] = '0;
        cfg[REG_MOD_D] = mod_d;
        cfg[REG_SRC_A] = src_a;
        cfg[REG_SRC_B] = src_b;
        cfg[REG_VAL_C] = val_c;
        cfg[REG_DST_D] = dst_d;
        cfg[REG_LINES] = lines;
        cfg[REG_WORDS] = words;
    endtask

    // writes all registers, WORDS last so that it queues the blit
    task automatic program_blit(input string test);
        wait_not_full(test);
        for (int r = 0; r < 12; r++) begin
            @(posedge clk);
            #1;
            regs_wr_i  = 1'b1;
            reg_num_i  = reg_num_t'(r);
            reg_data_i = cfg[r];
        end
        @(posedge clk);
        #1;
        regs_wr_i = 1'b0;
        reference_blit();
    endtask

    task automatic run_blit(input string test);
        program_blit(test);
        wait_done(test);
        @(posedge clk);
        #1;
        check_value(test, "busy after done", 0, int'(busy_o));
        check_memory(test);
    endtask

    task automatic fill_random(input addr_t base, input int count);
        word_t v;
        for (int i = 0; i < count; i++) begin
            v = word_t'($urandom);
            mem[base + addr_t'(i)]     = v;
            exp_mem[base + addr_t'(i)] = v;
        end
    endtask

    // bytes 3c and 50 are see-through for the transparency tests
    task automatic fill_sprite(input addr_t base, input int count);
        word_t v;
        for (int i = 0; i < count; i++) begin
            for (int k = 0; k < 2; k++) begin
                case ($urandom_range(3, 0))
                    0:       v[8*k +: 8] = 8'h3C;
                    1:       v[8*k +: 8] = 8'h50;
                    2:       v[8*k +: 8] = 8'h05;
                    default: v[8*k +: 8] = 8'($urandom);
                endcase
            end
            mem[base + addr_t'(i)]     = v;
            exp_mem[base + addr_t'(i)] = v;
        end
    endtask

    initial begin
        int reads_before;
        void'($urandom(32'h99255f53));
        reset_i    = 1'b1;
        regs_wr_i  = 1'b0;
        reg_num_i  = '0;
        reg_data_i = '0;
        prev_a     = '0;
        prev_b     = '0;
        exp_reads  = 0;
        exp_writes = 0;
        exp_max_wr = -1;
        for (int i = 0; i < 65536; i++) begin
            mem[i]     = word_t'(i * 40503) ^ {i[7:0], i[15:8]};
            exp_mem[i] = mem[i];
        end
        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_value("reset", "status bits", 0,
                    int'({busy_o, full_o, done_o, vram_sel_o, vram_wr_o}));

        fill_random(16'h1000, 64);
        set_blit(16'h0002, 16'hFF00, 16'h1000, 16'hFFFF, 16'h0000, 16'h2000,
                 16'd12, 16'd0, 16'd16, 16'd2, 16'd3);
        run_blit("plain copy");

        set_blit(16'h0002, 16'h7E01, 16'h1000, 16'hFFFF, 16'h0000, 16'h2100,
                 16'd11, 16'd0, 16'd15, 16'd3, 16'd4);
        run_blit("shift 1 with masks");
        set_blit(16'h0002, 16'h7E02, 16'h1000, 16'hFFFF, 16'h0000, 16'h2200,
                 16'd11, 16'd0, 16'd15, 16'd3, 16'd4);
        run_blit("shift 2 with masks");

        fill_sprite(16'h3000, 48);
        set_blit(16'h5001, 16'hFF00, 16'hFFFF, 16'h3000, 16'h0000, 16'h2300,
                 16'd0, 16'd2, 16'd10, 16'd3, 16'd5);
        run_blit("transparency 4 bit");
        set_blit(16'h3C21, 16'hFF00, 16'hFFFF, 16'h3000, 16'h0000, 16'h2400,
                 16'd0, 16'd2, 16'd10, 16'd3, 16'd5);
        run_blit("transparency 8 bit");

        fill_random(16'h5000, 128);
        set_blit(16'h0004, 16'hFF03, 16'h5000, 16'h5040, word_t'($urandom), 16'h2500,
                 16'd4, 16'd4, 16'd9, 16'd2, 16'd6);
        run_blit("a and not b xor c");
        set_blit(16'h0008, 16'hFF00, 16'h5000, 16'h5040, 16'h0000, 16'h2600,
                 16'd4, 16'd4, 16'd9, 16'd2, 16'd6);
        run_blit("not a and b");
        set_blit(16'h000C, 16'hFF01, 16'h5000, 16'h5040, 16'h0000, 16'h2700,
                 16'd4, 16'd4, 16'd9, 16'd2, 16'd6);
        run_blit("a or b");

        reads_before = reads;
        set_blit(16'h0003, 16'hFF00, 16'hA5C3, 16'hFFFF, 16'h0000, 16'h2800,
                 16'd0, 16'd0, 16'd6, 16'd4, 16'd9);
        run_blit("fill");
        check_value("fill", "reads during fill", reads_before, reads);

        // second blit goes into the queue while the first one runs
        set_blit(16'h0002, 16'hFF00, 16'h5000, 16'hFFFF, 16'h0000, 16'h2900,
                 16'd8, 16'd0, 16'd8, 16'd5, 16'd7);
        program_blit("back to back");
        set_blit(16'h000C, 16'hFF00, 16'h5010, 16'h5050, 16'h0000, 16'h2A00,
                 16'd3, 16'd3, 16'd3, 16'd2, 16'd4);
        program_blit("back to back");
        check_value("back to back", "full while running", 1, int'(full_o));
        wait_done("back to back first");
        @(posedge clk);
        #1;
        check_value("back to back", "busy between blits", 1, int'(busy_o));
        wait_done("back to back second");
        @(posedge clk);
        #1;
        check_value("back to back", "busy after done", 0, int'(busy_o));
        check_memory("back to back");

        for (int t = 0; t < 8; t++) begin
            set_blit(word_t'($urandom) & 16'hFF2F, word_t'($urandom) & 16'hFF03,
                     word_t'($urandom), word_t'($urandom), word_t'($urandom),
                     word_t'($urandom), word_t'($urandom_range(31, 0)),
                     word_t'($urandom_range(31, 0)), word_t'($urandom_range(31, 0)),
                     word_t'($urandom_range(5, 0)), word_t'($urandom_range(9, 0)));
            run_blit($sformatf("random %0d", t));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
